//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module conv_datapath_tb \
    -f tb.f \
    -o conv_datapath_tb

# grep fails the script when the pass line is missing
./obj_dir/conv_datapath_tb | tee /dev/stderr | grep "RESULT: PASS" > /dev/null

//--- src/conv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               start,
    input  wire logic               mode,
    input  wire conv_pkg::mac_cnt_t mac_len,
    input  wire conv_pkg::pix_cnt_t out_pixels,
    input  wire conv_pkg::shift_t   shift,
    input  wire logic               pixel_valid,
    input  wire conv_pkg::pixel_t   pixel,
    input  wire logic               weight_we,
    input  wire conv_pkg::chan_t    weight_chan,
    input  wire conv_pkg::mac_cnt_t weight_addr,
    input  wire conv_pkg::weight_t  weight_data,
    input  wire logic               bias_we,
    input  wire conv_pkg::chan_t    bias_chan,
    input  wire conv_pkg::bias_t    bias_data,
    output logic                    out_valid,
    output conv_pkg::chan_t         out_chan,
    output conv_pkg::result_t       out_data,
    output logic                    busy
);

    logic               beat_valid;
    logic               beat_first;
    logic               beat_last;
    conv_pkg::pixel_t   beat_pixel;
    conv_pkg::mac_cnt_t beat_idx;
    logic               mode_q;
    logic               drain_busy;

    logic [conv_pkg::PE_NUM-1:0] pe_we;
    logic [conv_pkg::PE_NUM-1:0] pe_acc_valid;
    conv_pkg::acc_t              acc_bus [conv_pkg::PE_NUM];

    conv_pkg::shift_t shift_q;  // held for the whole run

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '0;
        end else if (start && !busy) begin
            shift_q <= shift;
        end
    end

    conv_feeder feeder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .mode        (mode),
        .mac_len     (mac_len),
        .out_pixels  (out_pixels),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .drain_busy  (drain_busy),
        .busy        (busy),
        .beat_valid  (beat_valid),
        .beat_first  (beat_first),
        .beat_last   (beat_last),
        .beat_pixel  (beat_pixel),
        .beat_idx    (beat_idx),
        .mode_q      (mode_q)
    );

    ////////////////////
    // one pe per output channel
    ////////////////////

    for (genvar i = 0; i < conv_pkg::PE_NUM; i++) begin : g_pe
        assign pe_we[i] = weight_we && (weight_chan == conv_pkg::chan_t'(i));

        conv_pe pe_i (
            .clk         (clk),
            .arst_n      (arst_n),
            .weight_we   (pe_we[i]),
            .weight_addr (weight_addr),
            .weight_data (weight_data),
            .beat_valid  (beat_valid),
            .beat_first  (beat_first),
            .beat_last   (beat_last),
            .beat_pixel  (beat_pixel),
            .beat_idx    (beat_idx),
            .mode_q      (mode_q),
            .acc_valid   (pe_acc_valid[i]),
            .acc         (acc_bus[i])
        );
    end

    conv_drain drain_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .bias_we    (bias_we),
        .bias_chan  (bias_chan),
        .bias_data  (bias_data),
        .shift      (shift_q),
        .acc_valid  (pe_acc_valid[0]),  // all pes finish together
        .acc_bus    (acc_bus),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .drain_busy (drain_busy)
    );

    // weight and bias stores only change between runs
    a_load_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (weight_we || bias_we) |-> !busy)
        else $error("conv_datapath: weight or bias write while busy");

endmodule

`default_nettype wire

//--- src/conv_drain.sv
`timescale 1ns/1ps
`default_nettype none

module conv_drain (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             bias_we,
    input  wire conv_pkg::chan_t  bias_chan,
    input  wire conv_pkg::bias_t  bias_data,
    input  wire conv_pkg::shift_t shift,
    input  wire logic             acc_valid,
    input  wire conv_pkg::acc_t   acc_bus [conv_pkg::PE_NUM],
    output logic                  out_valid,
    output conv_pkg::chan_t       out_chan,
    output conv_pkg::result_t     out_data,
    output logic                  drain_busy
);

    conv_pkg::bias_t bias_mem [conv_pkg::PE_NUM];
    conv_pkg::acc_t  acc_q    [conv_pkg::PE_NUM];

    logic            emitting;   // channels 1.. still to go
    conv_pkg::chan_t emit_chan;

    conv_pkg::chan_t   sel_chan;
    conv_pkg::acc_t    sel_acc;
    conv_pkg::acc_t    sum;
    conv_pkg::acc_t    shifted;
    conv_pkg::result_t sat;

    ////////////////////
    // bias store
    ////////////////////

    always_ff @(posedge clk) begin
        if (bias_we) begin
            bias_mem[bias_chan] <= bias_data;
        end
    end

    ////////////////////
    // accumulator capture
    ////////////////////

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            for (int i = 0; i < conv_pkg::PE_NUM; i++) begin
                acc_q[i] <= acc_bus[i];
            end
        end
    end

    // channel 0 goes straight from the pe, the rest from the capture regs
    assign sel_chan = acc_valid ? conv_pkg::chan_t'(0) : emit_chan;
    assign sel_acc  = acc_valid ? acc_bus[0] : acc_q[emit_chan];

    ////////////////////
    // bias, shift, clamp
    ////////////////////

    always_comb begin
        sum     = sel_acc + conv_pkg::acc_t'(bias_mem[sel_chan]);
        shifted = sum >>> shift;  // floor toward -inf
        if (shifted > conv_pkg::SAT_MAX) begin
            sat = conv_pkg::result_t'(conv_pkg::SAT_MAX);
        end else if (shifted < conv_pkg::SAT_MIN) begin
            sat = conv_pkg::result_t'(conv_pkg::SAT_MIN);
        end else begin
            sat = conv_pkg::result_t'(shifted);
        end
    end

    ////////////////////
    // serial output
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            emitting  <= 1'b0;
            emit_chan <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc_valid || emitting;
            if (acc_valid) begin
                emitting  <= 1'b1;
                emit_chan <= conv_pkg::chan_t'(1);
            end else if (emitting) begin
                emit_chan <= emit_chan + conv_pkg::chan_t'(1);
                if (emit_chan == conv_pkg::chan_t'(conv_pkg::PE_NUM - 1)) begin
                    emitting <= 1'b0;  // last channel out this cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid || emitting) begin
            out_chan <= sel_chan;
            out_data <= sat;
        end
    end

    assign drain_busy = acc_valid || emitting;

    // windows shorter than PE_NUM beats would overrun the serial output
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        acc_valid |-> !emitting)
        else $error("conv_drain: acc_valid while channels still pending");

endmodule

`default_nettype wire

//--- src/conv_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module conv_feeder (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               start,
    input  wire logic               mode,
    input  wire conv_pkg::mac_cnt_t mac_len,
    input  wire conv_pkg::pix_cnt_t out_pixels,
    input  wire logic               pixel_valid,
    input  wire conv_pkg::pixel_t   pixel,
    input  wire logic               drain_busy,
    output logic                    busy,
    output logic                    beat_valid,
    output logic                    beat_first,
    output logic                    beat_last,
    output conv_pkg::pixel_t        beat_pixel,
    output conv_pkg::mac_cnt_t      beat_idx,
    output logic                    mode_q
);

    conv_pkg::feed_state_t state;

    conv_pkg::mac_cnt_t mac_len_q;     // latched config
    conv_pkg::pix_cnt_t out_pixels_q;
    conv_pkg::mac_cnt_t mac_idx;       // position inside current window
    conv_pkg::pix_cnt_t win_cnt;       // windows finished so far
    logic [1:0]         flush_cnt;

    logic accept;
    logic win_done;
    logic last_win;

    assign accept   = (state == conv_pkg::run) && pixel_valid;  // idle pixels dropped
    assign win_done = (mac_idx == conv_pkg::mac_cnt_t'(mac_len_q - conv_pkg::mac_cnt_t'(1)));
    assign last_win = (win_cnt == conv_pkg::pix_cnt_t'(out_pixels_q - conv_pkg::pix_cnt_t'(1)));
    assign busy     = (state != conv_pkg::idle);

    ////////////////////
    // control fsm
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= conv_pkg::idle;
            mode_q       <= 1'b0;
            mac_len_q    <= '0;
            out_pixels_q <= '0;
            mac_idx      <= '0;
            win_cnt      <= '0;
            flush_cnt    <= '0;
        end else begin
            unique case (state)
                conv_pkg::idle: begin
                    if (start) begin
                        mode_q       <= mode;
                        mac_len_q    <= mac_len;
                        out_pixels_q <= out_pixels;
                        mac_idx      <= '0;
                        win_cnt      <= '0;
                        state        <= conv_pkg::run;
                    end
                end
                conv_pkg::run: begin
                    if (pixel_valid) begin
                        if (win_done) begin
                            mac_idx <= '0;
                            win_cnt <= win_cnt + conv_pkg::pix_cnt_t'(1);
                            if (last_win) begin
                                flush_cnt <= 2'(conv_pkg::FLUSH_CYCLES);
                                state     <= conv_pkg::drain_wait;
                            end
                        end else begin
                            mac_idx <= mac_idx + conv_pkg::mac_cnt_t'(1);
                        end
                    end
                end
                conv_pkg::drain_wait: begin
                    // let the last beat reach the drain before trusting drain_busy
                    if (flush_cnt != 2'd0) begin
                        flush_cnt <= flush_cnt - 2'd1;
                    end else if (!drain_busy) begin
                        state <= conv_pkg::idle;
                    end
                end
                default: state <= conv_pkg::idle;
            endcase
        end
    end

    ////////////////////
    // beat broadcast
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_valid <= 1'b0;
            beat_first <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= accept;
            beat_first <= accept && (mac_idx == '0);
            beat_last  <= accept && win_done;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_pixel <= pixel;
            beat_idx   <= mac_idx;  // weight address for the pes
        end
    end

    // a new run only starts from idle
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
        else $error("conv_feeder: start while busy");

endmodule

`default_nettype wire

//--- src/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pe (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               weight_we,
    input  wire conv_pkg::mac_cnt_t weight_addr,
    input  wire conv_pkg::weight_t  weight_data,
    input  wire logic               beat_valid,
    input  wire logic               beat_first,
    input  wire logic               beat_last,
    input  wire conv_pkg::pixel_t   beat_pixel,
    input  wire conv_pkg::mac_cnt_t beat_idx,
    input  wire logic               mode_q,
    output logic                    acc_valid,
    output conv_pkg::acc_t          acc
);

    conv_pkg::weight_t weight_mem [conv_pkg::MAC_MAX];

    conv_pkg::weight_t  weight;
    logic signed [15:0] prod_8x8;
    conv_pkg::acc_t     prod_1x8;
    conv_pkg::acc_t     prod;

    conv_pkg::acc_t prod_q;
    logic           prod_valid;
    logic           prod_first;
    logic           prod_last;

    ////////////////////
    // weight store
    ////////////////////

    always_ff @(posedge clk) begin
        if (weight_we) begin
            weight_mem[weight_addr[conv_pkg::MAC_AW-1:0]] <= weight_data;
        end
    end

    assign weight = weight_mem[beat_idx[conv_pkg::MAC_AW-1:0]];

    ////////////////////
    // multiply
    ////////////////////

    always_comb begin
        prod_8x8 = beat_pixel * weight;  // signed 8x8
        // 1x8 mode, bit set adds the pixel, bit clear subtracts it
        prod_1x8 = weight[0] ? conv_pkg::acc_t'(beat_pixel) : -conv_pkg::acc_t'(beat_pixel);
        prod     = mode_q ? prod_1x8 : conv_pkg::acc_t'(prod_8x8);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= beat_valid;
            prod_first <= beat_valid && beat_first;
            prod_last  <= beat_valid && beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            prod_q <= prod;
        end
    end

    ////////////////////
    // accumulate
    ////////////////////

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            acc <= prod_first ? prod_q : acc + prod_q;  // first beat restarts the sum
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod_valid && prod_last;  // one cycle, with the final acc
        end
    end

endmodule

`default_nettype wire

//--- src/conv_pkg.sv
`default_nettype none

package conv_pkg;

    ////////////////////
    // array sizes
    ////////////////////

    localparam int PE_NUM  = 4;               // output channels, one pe each
    localparam int MAC_MAX = 16;              // deepest window, weight store depth
    localparam int MAC_AW  = $clog2(MAC_MAX); // weight store address bits

    // pipeline beats between the last beat and acc_valid in the pe
    localparam int FLUSH_CYCLES = 2;

    ////////////////////
    // datapath widths
    ////////////////////

    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;  // mode 1 only looks at bit 0
    typedef logic signed [23:0] acc_t;     // 16 bit product + 8 bit headroom
    typedef logic signed [7:0]  bias_t;
    typedef logic signed [7:0]  result_t;

    typedef logic [4:0]  mac_cnt_t;   // index inside a window, or its length
    typedef logic [15:0] pix_cnt_t;   // output pixels per run
    typedef logic [1:0]  chan_t;      // output channel
    typedef logic [3:0]  shift_t;     // arithmetic right shift of the result

    // clamp limits of the 8 bit result, held at accumulator width
    localparam acc_t SAT_MAX = acc_t'(127);
    localparam acc_t SAT_MIN = acc_t'(-128);

    ////////////////////
    // feeder fsm
    ////////////////////

    typedef enum logic [1:0] {
        idle       = 2'd0,
        run        = 2'd1,
        drain_wait = 2'd2  // stream done, outputs still in flight
    } feed_state_t;

endpackage

`default_nettype wire

//--- tb.f
src/conv_pkg.sv
src/conv_feeder.sv
src/conv_pe.sv
src/conv_drain.sv
src/conv_datapath.sv
testbench/tb_clock.sv
testbench/conv_datapath_tb.sv

//--- testbench/conv_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath_tb;

    typedef struct packed {
        logic               mode;
        conv_pkg::mac_cnt_t mac_len;
        conv_pkg::pix_cnt_t out_pixels;
        conv_pkg::shift_t   shift;
        logic               gap;       // idle cycles between pixels
        logic [7:0]         seed_ofs;  // random draws skipped before the pixels
    } case_t;

    localparam int NUM_CASES = 7;

    // mode, mac_len, out_pixels, shift, gap, seed offset
    case_t cases [NUM_CASES] = '{
        '{1'b0, 5'd4,  16'd5, 4'd10, 1'b0, 8'd0},
        '{1'b0, 5'd9,  16'd4, 4'd11, 1'b1, 8'd3},
        '{1'b0, 5'd16, 16'd4, 4'd12, 1'b0, 8'd7},
        '{1'b0, 5'd16, 16'd4, 4'd0,  1'b1, 8'd2},  // overflows, clamps
        '{1'b1, 5'd9,  16'd5, 4'd2,  1'b0, 8'd1},
        '{1'b1, 5'd16, 16'd3, 4'd3,  1'b1, 8'd5},
        '{1'b0, 5'd4,  16'd3, 4'd9,  1'b1, 8'd4}
    };

    logic               clk;
    logic               arst_n;
    logic               start;
    logic               mode;
    conv_pkg::mac_cnt_t mac_len;
    conv_pkg::pix_cnt_t out_pixels;
    conv_pkg::shift_t   shift;
    logic               pixel_valid;
    conv_pkg::pixel_t   pixel;
    logic               weight_we;
    conv_pkg::chan_t    weight_chan;
    conv_pkg::mac_cnt_t weight_addr;
    conv_pkg::weight_t  weight_data;
    logic               bias_we;
    conv_pkg::chan_t    bias_chan;
    conv_pkg::bias_t    bias_data;
    logic               out_valid;
    conv_pkg::chan_t    out_chan;
    conv_pkg::result_t  out_data;
    logic               busy;

    // reference model state
    int   weights [conv_pkg::PE_NUM][conv_pkg::MAC_MAX];
    int   biases  [conv_pkg::PE_NUM];
    int   pixels  [$];
    int   exp_chan [$];
    int   exp_data [$];
    int   rd_ptr;       // next expected result
    int   beats_total;
    logic burst_open;   // channels of a window still owed
    logic sat_hi_seen;
    logic sat_lo_seen;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    conv_datapath dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .mode        (mode),
        .mac_len     (mac_len),
        .out_pixels  (out_pixels),
        .shift       (shift),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .weight_we   (weight_we),
        .weight_chan (weight_chan),
        .weight_addr (weight_addr),
        .weight_data (weight_data),
        .bias_we     (bias_we),
        .bias_chan   (bias_chan),
        .bias_data   (bias_data),
        .out_valid   (out_valid),
        .out_chan    (out_chan),
        .out_data    (out_data),
        .busy        (busy)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    function automatic int rand_s8();
        int v;
        v = int'($urandom % 256);
        return (v > 127) ? v - 256 : v;
    endfunction

    // one tap of a window
    function automatic int tap_product(input logic m, input int p, input int w);
        if (m) begin
            return (w % 2 != 0) ? p : -p;  // odd weight means bit 0 set
        end
        return p * w;
    endfunction

    // bias add, then divide by 2**sh rounding down
    function automatic int shifted_sum(input int acc, input int bias, input int sh);
        int sum;
        int pow;
        int q;
        sum = acc + bias;
        pow = 1 << sh;
        q   = sum / pow;  // truncates toward zero
        if (sum < 0 && q * pow != sum) begin
            q = q - 1;
        end
        return q;
    endfunction

    ////////////////////
    // one case
    ////////////////////

    task automatic run_case(input case_t tc);
        int n_taps;
        int acc;
        int res;
        int beats_before;
        n_taps = int'(tc.mac_len);

        for (int c = 0; c < conv_pkg::PE_NUM; c++) begin
            biases[c] = rand_s8();
            for (int a = 0; a < conv_pkg::MAC_MAX; a++) begin
                weights[c][a] = rand_s8();
                @(posedge clk);
                weight_we   <= 1'b1;
                weight_chan <= conv_pkg::chan_t'(c);
                weight_addr <= conv_pkg::mac_cnt_t'(a);
                weight_data <= conv_pkg::weight_t'(weights[c][a]);
                bias_we     <= (a == 0);  // bias rides along with tap 0
                bias_chan   <= conv_pkg::chan_t'(c);
                bias_data   <= conv_pkg::bias_t'(biases[c]);
            end
        end
        @(posedge clk);
        weight_we <= 1'b0;
        bias_we   <= 1'b0;

        repeat (int'(tc.seed_ofs)) void'($urandom);
        pixels.delete();
        for (int i = 0; i < n_taps * int'(tc.out_pixels); i++) begin
            pixels.push_back(rand_s8());
        end

        // expected results, window by window
        for (int w = 0; w < int'(tc.out_pixels); w++) begin
            for (int c = 0; c < conv_pkg::PE_NUM; c++) begin
                acc = 0;
                for (int i = 0; i < n_taps; i++) begin
                    acc += tap_product(tc.mode, pixels[w * n_taps + i], weights[c][i]);
                end
                res = shifted_sum(acc, biases[c], int'(tc.shift));
                if (res > 127) begin
                    res         = 127;
                    sat_hi_seen = 1'b1;
                end else if (res < -128) begin
                    res         = -128;
                    sat_lo_seen = 1'b1;
                end
                exp_chan.push_back(c);
                exp_data.push_back(res);
            end
        end

        beats_before = beats_total;
        repeat (2) begin
            @(posedge clk);
            pixel_valid <= 1'b1;  // idle, so dropped
            pixel       <= 8'sh7f;
        end
        @(posedge clk);
        pixel_valid <= 1'b0;
        start       <= 1'b1;
        mode        <= tc.mode;
        mac_len     <= tc.mac_len;
        out_pixels  <= tc.out_pixels;
        shift       <= tc.shift;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd1);

        foreach (pixels[i]) begin
            if (tc.gap && ($urandom % 2 == 1)) begin
                @(posedge clk);
                pixel_valid <= 1'b0;
                pixel       <= 8'sh55;  // junk under a low valid
            end
            @(posedge clk);
            pixel_valid <= 1'b1;
            pixel       <= conv_pkg::pixel_t'(pixels[i]);
        end
        // stray pixels after the last window
        repeat (2) begin
            @(posedge clk);
            pixel <= 8'sh80;
        end
        @(posedge clk);
        pixel_valid <= 1'b0;

        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("pending results", 32'(exp_data.size() - rd_ptr), 32'd0);
        check_value("out_valid beats", 32'(beats_total - beats_before),
                    32'(int'(tc.out_pixels) * conv_pkg::PE_NUM));
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    always @(negedge clk) begin
        if (!arst_n) begin
            rd_ptr      = 0;
            beats_total = 0;
            burst_open  = 1'b0;
        end else begin
            if (burst_open && !out_valid) begin
                abort_run("out_valid dropped before the last channel of a window");
            end
            burst_open = 1'b0;
            if (out_valid) begin
                if (rd_ptr >= exp_data.size()) begin
                    abort_run("out_valid with no result expected");
                end
                check_value("out_chan", 32'(out_chan), 32'(exp_chan[rd_ptr]));
                check_value("out_data", 32'(out_data), 32'(exp_data[rd_ptr]));
                check_value("busy", 32'(busy), 32'd1);
                burst_open = (int'(out_chan) != conv_pkg::PE_NUM - 1);
                rd_ptr++;
                beats_total++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        int cycles;
        limit = 200;
        for (int k = 0; k < NUM_CASES; k++) begin
            limit += int'(cases[k].out_pixels)
                     * (2 * int'(cases[k].mac_len) + conv_pkg::PE_NUM + 4);
            limit += conv_pkg::PE_NUM * conv_pkg::MAC_MAX + 16;  // store loads
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("timeout, run still going after %0d cycles", limit));
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        start       <= 1'b0;
        mode        <= 1'b0;
        mac_len     <= '0;
        out_pixels  <= '0;
        shift       <= '0;
        pixel_valid <= 1'b0;
        pixel       <= '0;
        weight_we   <= 1'b0;
        weight_chan <= '0;
        weight_addr <= '0;
        weight_data <= '0;
        bias_we     <= 1'b0;
        bias_chan   <= '0;
        bias_data   <= '0;
        sat_hi_seen = 1'b0;
        sat_lo_seen = 1'b0;
        void'($urandom(16));

        wait (arst_n === 1'b1);
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);

        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(cases[k]);
        end

        if (sat_hi_seen && sat_lo_seen) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("clamp cases never reached both 127 and -128");
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // released away from the active edge
    end

endmodule

`default_nettype wire
